// File: Makefile
TOP := cache_tb

.PHONY: all build run lint clean

all: run

build:
	verilator --binary --timing --assert -j 0 -f all.f --top-module $(TOP) -o $(TOP)

run: build
	./obj_dir/$(TOP) | tee sim.log
	grep -q "Regression passed" sim.log

lint:
	verilator --lint-only -Wall --timing -f all.f --top-module cache_top

clean:
	rm -rf obj_dir sim.log

// File: all.f
+incdir+include
src/cache_pkg.sv
src/way_if.sv
src/cmd_frontend.sv
src/cache_way.sv
src/line_update.sv
src/cache_top.sv
test/cache_tb.sv

// File: include/cache_config.svh
`ifndef CACHE_CONFIG_SVH
`define CACHE_CONFIG_SVH

// Directory geometry
`define CACHE_SETS 16   // Sets in the directory
`define CACHE_WAYS 4    // Ways per set

// Address layout, tag on top and byte offset at the bottom
`define ADDR_W     16   // Full address
`define OFFSET_W   6    // Byte in line
`define INDEX_W    4    // Set select
`define TAG_W      6    // Remaining upper bits

// Way numbering and LRU rank width
`define WAY_W      2

`endif

// File: src/cache_pkg.sv
`include "cache_config.svh"

package cache_pkg;

    typedef logic [`ADDR_W-1:0]  addr_t;     // Full byte address
    typedef logic [`INDEX_W-1:0] set_idx_t;  // Set field
    typedef logic [`TAG_W-1:0]   tag_t;      // Tag field
    typedef logic [`WAY_W-1:0]   way_idx_t;  // Way number
    typedef logic [`WAY_W-1:0]   lru_t;      // 0 is newest

    typedef enum logic [1:0] {
        MESI_I = 2'd0,                       // Invalid
        MESI_S = 2'd1,                       // Shared
        MESI_E = 2'd2,                       // Exclusive
        MESI_M = 2'd3                        // Modified
    } mesi_t;

    typedef enum logic [2:0] {
        CMD_READ       = 3'd0,               // Processor read
        CMD_WRITE      = 3'd1,               // Processor write
        CMD_SNOOP_READ = 3'd3,               // Another cache reads
        CMD_SNOOP_INV  = 3'd4,               // Another cache invalidates
        CMD_CLEAR      = 3'd7                // Wipe every line
    } cmd_t;

    typedef enum logic [2:0] {
        FE_IDLE,                             // Wait for req
        FE_LOOKUP,                           // Lookup pulse
        FE_UPDATE,                           // Wait for done
        FE_CLEAR,                            // Set sweep
        FE_ACK,                              // Ack up until req drops
        FE_RELEASE                           // Last ack cycle
    } fe_state_t;

endpackage

// File: src/cache_top.sv
`timescale 1ns/10ps
`include "cache_config.svh"

module cache_top import cache_pkg::*; (
    input  logic     clk,
    input  logic     arst_n,
    input  logic     req,                    // From trace source
    output logic     ack,
    input  cmd_t     cmd,
    input  addr_t    addr,
    input  logic     shared_in,              // Snoop result for read miss
    output logic     hit,
    output way_idx_t way,
    output mesi_t    state,
    output logic     writeback               // Dirty line must go to memory
);

    way_if bus ();                           // Front end, ways and updater

    cmd_t cmd_q;                             // Held command
    logic shared_q;
    logic done;                              // Updater finished

    cmd_frontend u_fe (
        .clk       (clk),
        .arst_n    (arst_n),
        .req       (req),
        .ack       (ack),
        .cmd       (cmd),
        .addr      (addr),
        .shared_in (shared_in),
        .bus       (bus.fe),
        .done      (done),
        .cmd_q     (cmd_q),
        .shared_q  (shared_q)
    );

    // One storage slice per way
    for (genvar w = 0; w < `CACHE_WAYS; w++) begin : g_way
        cache_way #(
            .WAY_ID (w)
        ) u_way (
            .clk    (clk),
            .arst_n (arst_n),
            .bus    (bus.way)
        );
    end

    line_update u_upd (
        .clk       (clk),
        .arst_n    (arst_n),
        .bus       (bus.upd),
        .cmd       (cmd_q),
        .shared_in (shared_q),
        .done      (done),
        .hit       (hit),
        .way       (way),
        .state     (state),
        .writeback (writeback)
    );

endmodule

// File: src/cache_way.sv
`timescale 1ns/10ps
`include "cache_config.svh"

module cache_way import cache_pkg::*; #(
    parameter int WAY_ID = 0                 // Position in the set
) (
    input  logic clk,
    input  logic arst_n,
    way_if.way   bus
);

    tag_t  tag_mem  [`CACHE_SETS];           // Tag per set
    mesi_t mesi_mem [`CACHE_SETS];           // Coherence state per set
    lru_t  lru_mem  [`CACHE_SETS];           // Rank per set

    logic  hit_q;                            // Registered compare
    mesi_t mesi_q;
    lru_t  lru_q;
    logic  upd_q;                            // Update cycle follows lookup

    // Line storage
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            for (int s = 0; s < `CACHE_SETS; s++) begin
                tag_mem[s]  <= '0;
                mesi_mem[s] <= MESI_I;
                lru_mem[s]  <= lru_t'(WAY_ID);   // Initial rank equals way number
            end
        end else if (bus.clear) begin
            tag_mem[bus.set_idx]  <= '0;         // One set per cycle
            mesi_mem[bus.set_idx] <= MESI_I;
            lru_mem[bus.set_idx]  <= lru_t'(WAY_ID);
        end else begin
            if (bus.wr_en[WAY_ID]) begin
                tag_mem[bus.set_idx]  <= bus.wr_tag;
                mesi_mem[bus.set_idx] <= bus.wr_mesi_vec[WAY_ID];
            end
            if (upd_q) begin
                lru_mem[bus.set_idx] <= bus.wr_lru_vec[WAY_ID];  // Every way re-ranked
            end
        end
    end

    // Indexed line captured on lookup
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            upd_q  <= 1'b0;
            hit_q  <= 1'b0;
            mesi_q <= MESI_I;
            lru_q  <= '0;
        end else begin
            upd_q <= bus.lookup;
            if (bus.lookup) begin
                hit_q  <= (tag_mem[bus.set_idx] == bus.tag) &&
                          (mesi_mem[bus.set_idx] != MESI_I);  // Invalid line never hits
                mesi_q <= mesi_mem[bus.set_idx];
                lru_q  <= lru_mem[bus.set_idx];
            end
        end
    end

    assign bus.hit_vec[WAY_ID]  = hit_q;
    assign bus.mesi_vec[WAY_ID] = mesi_q;
    assign bus.lru_vec[WAY_ID]  = lru_q;

endmodule

// File: src/cmd_frontend.sv
`timescale 1ns/10ps
`include "cache_config.svh"

module cmd_frontend import cache_pkg::*; (
    input  logic     clk,
    input  logic     arst_n,
    input  logic     req,                    // Four-phase request
    output logic     ack,                    // Four-phase acknowledge
    input  cmd_t     cmd,
    input  addr_t    addr,
    input  logic     shared_in,              // Snoop result for a read miss
    way_if.fe        bus,
    input  logic     done,                   // Response registered
    output cmd_t     cmd_q,
    output logic     shared_q
);

    fe_state_t state_q;
    fe_state_t state_d;
    set_idx_t  sweep_q;                      // Clear pointer
    set_idx_t  idx_q;                        // Captured set field
    tag_t      tag_q;                        // Captured tag field
    logic      start;                        // New command accepted

    assign start = (state_q == FE_IDLE) && req;

    always_comb begin
        state_d = state_q;
        case (state_q)
            FE_IDLE: begin
                if (req) begin
                    state_d = (cmd == CMD_CLEAR) ? FE_CLEAR : FE_LOOKUP;
                end
            end
            FE_LOOKUP:  state_d = FE_UPDATE;     // Ways latch the line here
            FE_CLEAR: begin
                if (sweep_q == set_idx_t'(`CACHE_SETS - 1)) begin
                    state_d = FE_UPDATE;         // Last set wiped
                end
            end
            FE_UPDATE: begin
                if (done) begin
                    state_d = FE_ACK;
                end
            end
            FE_ACK: begin
                if (!req) begin
                    state_d = FE_RELEASE;        // Master saw ack
                end
            end
            FE_RELEASE: state_d = FE_IDLE;
            default:    state_d = FE_IDLE;
        endcase
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            state_q <= FE_IDLE;
            sweep_q <= '0;
        end else begin
            state_q <= state_d;
            if (start) begin
                sweep_q <= '0;                   // Sweep starts at set 0
            end else if (state_q == FE_CLEAR) begin
                sweep_q <= sweep_q + 1'b1;
            end
        end
    end

    // Command held for the whole transaction
    always_ff @(posedge clk) begin
        if (start) begin
            cmd_q    <= cmd;
            shared_q <= shared_in;
            idx_q    <= addr[`OFFSET_W +: `INDEX_W];
            tag_q    <= addr[`ADDR_W-1 -: `TAG_W];
        end
    end

    assign bus.set_idx = (state_q == FE_CLEAR) ? sweep_q : idx_q;
    assign bus.tag     = tag_q;
    assign bus.lookup  = (state_q == FE_LOOKUP);
    assign bus.clear   = (state_q == FE_CLEAR);

    assign ack = (state_q == FE_ACK) || (state_q == FE_RELEASE);  // Up one cycle past req low

endmodule

// File: src/line_update.sv
`timescale 1ns/10ps
`include "cache_config.svh"

module line_update import cache_pkg::*; (
    input  logic     clk,
    input  logic     arst_n,
    way_if.upd       bus,
    input  cmd_t     cmd,                    // Held command
    input  logic     shared_in,              // Held snoop result
    output logic     done,                   // One-cycle completion
    output logic     hit,
    output way_idx_t way,
    output mesi_t    state,
    output logic     writeback
);

    logic     lookup_q;                      // Ways hold the line now
    logic     clear_q;
    logic     clear_end;                     // Sweep just finished
    logic     any_hit;
    logic     inv_found;
    logic     is_proc;
    logic     is_snoop;
    logic     touch;                         // Command changes the set
    logic     do_write;
    logic     wb_flag;
    way_idx_t hit_way;
    way_idx_t inv_way;
    way_idx_t old_way;                       // Rank CACHE_WAYS-1
    way_idx_t sel_way;
    mesi_t    cur_state;
    mesi_t    next_state;
    lru_t     sel_rank;

    // Way selection; downward scan lets the lowest index win
    always_comb begin
        any_hit   = 1'b0;
        inv_found = 1'b0;
        hit_way   = '0;
        inv_way   = '0;
        old_way   = '0;
        for (int i = `CACHE_WAYS - 1; i >= 0; i--) begin
            if (bus.hit_vec[i]) begin
                any_hit = 1'b1;
                hit_way = way_idx_t'(i);
            end
            if (bus.mesi_vec[i] == MESI_I) begin
                inv_found = 1'b1;
                inv_way   = way_idx_t'(i);
            end
            if (bus.lru_vec[i] == lru_t'(`CACHE_WAYS - 1)) begin
                old_way = way_idx_t'(i);
            end
        end
        sel_way   = any_hit ? hit_way : (inv_found ? inv_way : old_way);
        cur_state = bus.mesi_vec[sel_way];
        sel_rank  = bus.lru_vec[sel_way];
    end

    // MESI next state and writeback
    always_comb begin
        is_proc    = (cmd == CMD_READ) || (cmd == CMD_WRITE);
        is_snoop   = (cmd == CMD_SNOOP_READ) || (cmd == CMD_SNOOP_INV);
        touch      = is_proc || (is_snoop && any_hit);
        do_write   = lookup_q && touch;
        next_state = MESI_I;                     // Snoop miss and no-op
        wb_flag    = 1'b0;
        case (cmd)
            CMD_READ: begin
                next_state = any_hit ? cur_state : (shared_in ? MESI_S : MESI_E);
                wb_flag    = !any_hit && (cur_state == MESI_M);  // Dirty victim
            end
            CMD_WRITE: begin
                next_state = MESI_M;
                wb_flag    = !any_hit && (cur_state == MESI_M);
            end
            CMD_SNOOP_READ: begin
                if (any_hit) begin
                    next_state = MESI_S;         // M and E drop to S
                    wb_flag    = (cur_state == MESI_M);
                end
            end
            CMD_SNOOP_INV: begin
                if (any_hit) begin
                    next_state = MESI_I;
                    wb_flag    = (cur_state == MESI_M);
                end
            end
            default: ;                           // Unknown code does nothing
        endcase
    end

    // Write strobes and new ranks
    always_comb begin
        for (int i = 0; i < `CACHE_WAYS; i++) begin
            bus.wr_en[i]       = do_write && (sel_way == way_idx_t'(i));
            bus.wr_mesi_vec[i] = (sel_way == way_idx_t'(i)) ? next_state : bus.mesi_vec[i];
            bus.wr_lru_vec[i]  = bus.lru_vec[i];  // Snoops keep ranks
            if (is_proc) begin
                if (sel_way == way_idx_t'(i)) begin
                    bus.wr_lru_vec[i] = '0;       // Touched way is newest
                end else if (bus.lru_vec[i] < sel_rank) begin
                    bus.wr_lru_vec[i] = bus.lru_vec[i] + 1'b1;  // Newer ways age by one
                end
            end
        end
    end

    assign bus.wr_tag = bus.tag;
    assign clear_end  = clear_q && !bus.clear;

    // Response held until the next command completes
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            lookup_q  <= 1'b0;
            clear_q   <= 1'b0;
            done      <= 1'b0;
            hit       <= 1'b0;
            way       <= '0;
            state     <= MESI_I;
            writeback <= 1'b0;
        end else begin
            lookup_q <= bus.lookup;
            clear_q  <= bus.clear;
            done     <= lookup_q || clear_end;
            if (lookup_q) begin
                hit       <= any_hit && (is_proc || is_snoop);
                way       <= touch ? sel_way : '0;
                state     <= next_state;
                writeback <= wb_flag;
            end else if (clear_end) begin
                hit       <= 1'b0;
                way       <= '0;
                state     <= MESI_I;
                writeback <= 1'b0;
            end
        end
    end

endmodule

// File: src/way_if.sv
`timescale 1ns/10ps
`include "cache_config.svh"

interface way_if import cache_pkg::*; ();

    // Broadcast from the front end
    set_idx_t set_idx;                       // Indexed set
    tag_t     tag;                           // Tag under lookup
    logic     lookup;                        // One-cycle lookup strobe
    logic     clear;                         // Sweep in progress

    // Indexed line from each way
    logic     hit_vec  [`CACHE_WAYS];        // Tag match on a valid line
    mesi_t    mesi_vec [`CACHE_WAYS];        // Current state
    lru_t     lru_vec  [`CACHE_WAYS];        // Current rank

    // New values from the updater
    logic     wr_en       [`CACHE_WAYS];     // Tag and state write
    tag_t     wr_tag;                        // Tag for the written way
    mesi_t    wr_mesi_vec [`CACHE_WAYS];     // Next state per way
    lru_t     wr_lru_vec  [`CACHE_WAYS];     // Next rank per way

    modport fe  (output set_idx, tag, lookup, clear);

    modport way (input  set_idx, tag, lookup, clear,
                 input  wr_en, wr_tag, wr_mesi_vec, wr_lru_vec,
                 output hit_vec, mesi_vec, lru_vec);

    modport upd (input  tag, lookup, clear,
                 input  hit_vec, mesi_vec, lru_vec,
                 output wr_en, wr_tag, wr_mesi_vec, wr_lru_vec);

endinterface

// File: test/cache_tb.sv
`timescale 1ns/10ps
`include "cache_config.svh"

module cache_tb import cache_pkg::*; ();

    localparam int N_ENTRIES    = 21;
    localparam int RESET_CYCLES = 5;
    localparam int TIMEOUT      = N_ENTRIES * (`CACHE_SETS + 10) + RESET_CYCLES;

    typedef struct packed {
        cmd_t     cmd;
        tag_t     tag;
        set_idx_t set;
        logic     shr;                       // shared_in for a read miss
        logic     hit;
        way_idx_t way;
        mesi_t    state;
        logic     wb;
    } entry_t;

    logic     clk;
    logic     arst_n;
    logic     req;
    logic     ack;
    cmd_t     cmd;
    addr_t    addr;
    logic     shared_in;
    logic     hit;
    way_idx_t way;
    mesi_t    state;
    logic     writeback;

    integer   seed      = 32'h54ddf8c0;      // Offset bits and hold time
    int       cur_entry = -1;
    int       cycle_cnt = 0;

    // Command, tag, set and shared_in, then expected hit, way, state and writeback
    entry_t tbl [N_ENTRIES] = '{
        '{CMD_CLEAR,      6'd0, 4'd0, 1'b0, 1'b0, 2'd0, MESI_I, 1'b0},  // Wipe after reset
        '{CMD_READ,       6'd1, 4'd2, 1'b0, 1'b0, 2'd0, MESI_E, 1'b0},  // First fill, exclusive
        '{CMD_READ,       6'd2, 4'd2, 1'b1, 1'b0, 2'd1, MESI_S, 1'b0},  // Shared fill
        '{CMD_READ,       6'd1, 4'd2, 1'b0, 1'b1, 2'd0, MESI_E, 1'b0},  // Read hit keeps E
        '{CMD_WRITE,      6'd1, 4'd2, 1'b0, 1'b1, 2'd0, MESI_M, 1'b0},  // Write hit
        '{CMD_WRITE,      6'd3, 4'd2, 1'b0, 1'b0, 2'd2, MESI_M, 1'b0},  // Write miss
        '{CMD_READ,       6'd4, 4'd2, 1'b0, 1'b0, 2'd3, MESI_E, 1'b0},  // Set now full
        '{CMD_READ,       6'd5, 4'd2, 1'b0, 1'b0, 2'd1, MESI_E, 1'b0},  // Evicts S way 1
        '{CMD_READ,       6'd6, 4'd2, 1'b1, 1'b0, 2'd0, MESI_S, 1'b1},  // Evicts M way 0
        '{CMD_SNOOP_READ, 6'd3, 4'd2, 1'b0, 1'b1, 2'd2, MESI_S, 1'b1},  // M to S, dirty
        '{CMD_SNOOP_READ, 6'd5, 4'd2, 1'b0, 1'b1, 2'd1, MESI_S, 1'b0},  // E to S
        '{CMD_SNOOP_INV,  6'd4, 4'd2, 1'b0, 1'b1, 2'd3, MESI_I, 1'b0},  // E dropped
        '{CMD_SNOOP_INV,  6'd9, 4'd2, 1'b0, 1'b0, 2'd0, MESI_I, 1'b0},  // Snoop miss
        '{CMD_READ,       6'd4, 4'd2, 1'b0, 1'b0, 2'd3, MESI_E, 1'b0},  // Refill way 3
        '{CMD_WRITE,      6'd5, 4'd2, 1'b0, 1'b1, 2'd1, MESI_M, 1'b0},  // S upgraded
        '{CMD_SNOOP_INV,  6'd5, 4'd2, 1'b0, 1'b1, 2'd1, MESI_I, 1'b1},  // M dropped, dirty
        '{CMD_READ,       6'd5, 4'd2, 1'b0, 1'b0, 2'd1, MESI_E, 1'b0},  // Way 1 reused
        '{CMD_READ,       6'd1, 4'd5, 1'b1, 1'b0, 2'd0, MESI_S, 1'b0},  // Other set
        '{CMD_CLEAR,      6'd0, 4'd0, 1'b0, 1'b0, 2'd0, MESI_I, 1'b0},
        '{CMD_READ,       6'd5, 4'd2, 1'b0, 1'b0, 2'd0, MESI_E, 1'b0},  // Gone after clear
        '{CMD_READ,       6'd0, 4'd0, 1'b1, 1'b0, 2'd0, MESI_S, 1'b0}   // Tag 0 line is invalid
    };

    cache_top uut (
        .clk       (clk),
        .arst_n    (arst_n),
        .req       (req),
        .ack       (ack),
        .cmd       (cmd),
        .addr      (addr),
        .shared_in (shared_in),
        .hit       (hit),
        .way       (way),
        .state     (state),
        .writeback (writeback)
    );

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;                // 4 ns period
    end

    task automatic stop_run(input string why);
        $display("%s", why);
        $display("Regression failed");
        $fatal(1, "Run stopped at the first error");
    endtask

    task automatic expect_value(input string name, input logic [31:0] got,
                                input logic [31:0] exp);
        assert (got === exp) else begin
            stop_run($sformatf("CHECK FAILED: %s entry %0d expected %0h got %0h",
                               name, cur_entry, exp, got));
        end
    endtask

    task automatic check_response(input entry_t e);
        expect_value("hit",       32'(hit),       32'(e.hit));
        expect_value("way",       32'(way),       32'(e.way));
        expect_value("state",     32'(state),     32'(e.state));
        expect_value("writeback", 32'(writeback), 32'(e.wb));
    endtask

    // Full four-phase handshake for one table entry
    task automatic run_entry(input entry_t e);
        logic [31:0] rnd;
        int          lat;
        int          exp_lat;
        int          hold;
        rnd     = $random(seed);
        exp_lat = (e.cmd == CMD_CLEAR) ? `CACHE_SETS + 2 : 3;
        hold    = int'(rnd[7:6]);             // Extra cycles with req held
        @(posedge clk);
        cmd       <= e.cmd;
        addr      <= {e.tag, e.set, rnd[5:0]};  // Offset bits must not matter
        shared_in <= e.shr;
        req       <= 1'b1;
        @(posedge clk);                       // This edge samples req
        lat = 0;
        @(negedge clk);
        while (!ack) begin
            @(posedge clk);
            lat++;
            @(negedge clk);
        end
        expect_value("ack latency", 32'(lat), 32'(exp_lat));
        check_response(e);
        repeat (hold) begin
            @(negedge clk);
            expect_value("ack", 32'(ack), 32'd1);  // Held under back-pressure
            check_response(e);
        end
        @(posedge clk);
        req <= 1'b0;
        @(posedge clk);                       // This edge samples req low
        lat = 0;
        @(negedge clk);
        while (ack) begin
            @(posedge clk);
            lat++;
            @(negedge clk);
        end
        expect_value("ack release", 32'(lat), 32'd1);  // One cycle after req low
    endtask

    always @(posedge clk) begin
        cycle_cnt <= cycle_cnt + 1;
        if (cycle_cnt >= TIMEOUT) begin
            stop_run($sformatf("Timeout: table not finished within %0d cycles", TIMEOUT));
        end
    end

    initial begin
        arst_n    = 1'b0;
        req       = 1'b0;
        cmd       = CMD_READ;
        addr      = '0;
        shared_in = 1'b0;
        repeat (RESET_CYCLES) @(posedge clk);
        arst_n <= 1'b1;
        @(negedge clk);
        expect_value("ack",       32'(ack),       32'd0);  // Idle outputs after reset
        expect_value("hit",       32'(hit),       32'd0);
        expect_value("way",       32'(way),       32'd0);
        expect_value("state",     32'(state),     32'(MESI_I));
        expect_value("writeback", 32'(writeback), 32'd0);
        for (int i = 0; i < N_ENTRIES; i++) begin
            cur_entry = i;
            run_entry(tbl[i]);
        end
        repeat (2) @(posedge clk);
        $display("Regression passed");
        $finish;
    end

endmodule
